//--- dcache_array.sv
`timescale 1ns/10ps
`include "dcache_settings.svh"

module dcache_array import dcache_pkg::*; #(
    parameter int unsigned WAY_ID = 0
) (
    input  logic         clk,
    input  logic         rst_n_i,
    input  dcache_addr_u rd_addr_i,
    input  dcache_tag_t  m1_tag_i,
    array_wr_if.array    wr,
    output logic         hit_o,
    output logic [31:0]  rdata_o
);

    localparam int unsigned WAY_SEL_W = $clog2(`DC_WAYS);
    localparam int unsigned WADDR_W = DC_INDEX_W + DC_WORD_W;

    logic [31:0]          data_mem [`DC_SETS * `DC_LINE_WORDS];
    dcache_tag_t          tag_mem  [`DC_SETS];
    logic [`DC_SETS-1:0]  line_valid;

    logic                 way_we;
    logic                 tag_write;
    logic [WADDR_W-1:0]   wr_waddr;
    logic [WADDR_W-1:0]   rd_waddr;
    logic [31:0]          rd_word_d;
    logic [31:0]          rd_word_q;
    dcache_tag_t          rd_tag_d;
    dcache_tag_t          rd_tag_q;
    logic                 rd_valid_d;
    logic                 rd_valid_q;

    assign way_we    = wr.wr_en && (wr.way_sel == WAY_SEL_W'(WAY_ID));
    assign tag_write = way_we && wr.tag_we;
    assign wr_waddr  = {wr.index, wr.word};
    assign rd_waddr  = {rd_addr_i.f.index, rd_addr_i.f.word};

    always_ff @(posedge clk) begin
        if (way_we) begin
            for (int b = 0; b < 4; b++) begin
                if (wr.strb[b]) begin
                    data_mem[wr_waddr][8*b +: 8] <= wr.wdata[8*b +: 8];
                end
            end
        end
        if (tag_write) begin
            tag_mem[wr.index] <= wr.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            line_valid <= '0;
        end else if (tag_write) begin
            line_valid[wr.index] <= 1'b1;
        end
    end

    // write-first bypass on a same-cycle write
    always_comb begin
        rd_word_d = data_mem[rd_waddr];
        for (int b = 0; b < 4; b++) begin
            if (way_we && wr_waddr == rd_waddr && wr.strb[b]) begin
                rd_word_d[8*b +: 8] = wr.wdata[8*b +: 8];
            end
        end
    end

    assign rd_tag_d = (tag_write && wr.index == rd_addr_i.f.index) ? wr.tag
                                                                 : tag_mem[rd_addr_i.f.index];
    assign rd_valid_d = (tag_write && wr.index == rd_addr_i.f.index)
                        || line_valid[rd_addr_i.f.index];

    always_ff @(posedge clk) begin
        rd_word_q <= rd_word_d;
        rd_tag_q  <= rd_tag_d;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_valid_d;
        end
    end

    assign hit_o   = rd_valid_q && (rd_tag_q == m1_tag_i);
    assign rdata_o = rd_word_q;

endmodule

//--- dcache_ctrl.sv
`timescale 1ns/10ps
`include "dcache_settings.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  logic [31:0]         req_addr_i,
    input  logic [31:0]         req_wdata_i,
    input  logic [3:0]          req_strb_i,
    input  logic [3:0]          req_rmask_i,
    input  logic [1:0]          req_size_i,
    input  logic                req_signed_i,
    input  logic [3:0]          req_id_i,
    output logic                resp_valid_o,
    input  logic                resp_ready_i,
    output logic [3:0]          resp_id_o,
    output logic                resp_hit_o,
    output logic [31:0]         resp_rdata_o,
    input  logic                fill_valid_i,
    input  logic                fill_way_i,
    input  logic [31:0]         fill_addr_i,
    input  logic [31:0]         fill_data_i,
    input  logic                fill_tag_we_i,
    input  logic                commit_i,
    sb_push_if.ctrl             push,
    array_wr_if.ctrl            wr,
    input  sb_entry_t           sb_head_i,
    input  logic                sb_empty_i,
    output logic                pop_o,
    input  logic [`DC_WAYS-1:0] way_hit_i,
    input  logic [3:0]          fwd_mask_i,
    input  logic [31:0]         load_data_i,
    output dcache_addr_u        rd_addr_o,
    output dcache_addr_u        m1_addr_o,
    output logic [3:0]          m1_rmask_o,
    output mem_size_e           m1_size_o,
    output logic                m1_signed_o
);

    logic         m1_valid;
    logic [31:0]  m1_wdata;
    logic [3:0]   m1_strb;
    logic [3:0]   m1_id;
    logic         m1_is_store;
    logic         m1_leave;
    logic         fwd_cover;
    dcache_addr_u fill_addr;

    assign m1_is_store = |m1_strb;

    // a store also needs room in the store buffer
    assign m1_leave = resp_ready_i && (!m1_is_store || push.push_ready);
    assign req_ready_o = !flush_i && !(m1_valid && !m1_leave);

    // keep re-reading the M1 address while it stalls
    assign rd_addr_o = req_ready_o ? dcache_addr_u'(req_addr_i) : m1_addr_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            m1_valid <= 1'b0;
        end else if (flush_i) begin
            m1_valid <= 1'b0;
        end else if (req_ready_o) begin
            m1_valid <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            m1_addr_o   <= req_addr_i;
            m1_wdata    <= req_wdata_i;
            m1_strb     <= req_strb_i;
            m1_rmask_o  <= req_rmask_i;
            m1_size_o   <= mem_size_e'(req_size_i);
            m1_signed_o <= req_signed_i;
            m1_id       <= req_id_i;
        end
    end

    // store entry carries the way that hit in M1
    assign push.push_valid = m1_valid && m1_is_store && resp_ready_i && !flush_i;
    assign push.push_entry = '{addr: m1_addr_o, wdata: m1_wdata, strb: m1_strb,
                               way_hit: way_hit_i};

    assign fwd_cover = (|m1_rmask_o) && ((fwd_mask_i & m1_rmask_o) == m1_rmask_o);

    assign resp_valid_o = m1_valid && !flush_i && (!m1_is_store || push.push_ready);
    assign resp_id_o    = m1_id;
    assign resp_hit_o   = (|way_hit_i) || (!m1_is_store && fwd_cover);
    assign resp_rdata_o = m1_is_store ? 32'd0 : load_data_i;

    // fill has priority, a commit in the same cycle is lost
    assign pop_o = commit_i && !fill_valid_i && !sb_empty_i;
    assign fill_addr = fill_addr_i;

    always_comb begin
        wr.wr_en   = 1'b0;
        wr.tag_we  = 1'b0;
        wr.way_sel = '0;
        wr.index   = '0;
        wr.word    = '0;
        wr.tag     = '0;
        wr.wdata   = '0;
        wr.strb    = '0;
        if (fill_valid_i) begin
            wr.wr_en   = 1'b1;
            wr.tag_we  = fill_tag_we_i;
            wr.way_sel = fill_way_i;
            wr.index   = fill_addr.f.index;
            wr.word    = fill_addr.f.word;
            wr.tag     = fill_addr.f.tag;
            wr.wdata   = fill_data_i;
            wr.strb    = 4'hf;
        end else if (pop_o) begin
            // missed stores drain without a write
            wr.wr_en   = |sb_head_i.way_hit;
            wr.way_sel = sb_head_i.way_hit[1];
            wr.index   = sb_head_i.addr.f.index;
            wr.word    = sb_head_i.addr.f.word;
            wr.tag     = sb_head_i.addr.f.tag;
            wr.wdata   = sb_head_i.wdata;
            wr.strb    = sb_head_i.strb;
        end
    end

endmodule

//--- dcache_if.sv
`timescale 1ns/10ps
`include "dcache_settings.svh"

// M1 store into the store buffer
interface sb_push_if import dcache_pkg::*; ();

    logic      push_valid;
    logic      push_ready;
    sb_entry_t push_entry;

    modport ctrl (
        output push_valid,
        output push_entry,
        input  push_ready
    );

    modport sb (
        input  push_valid,
        input  push_entry,
        output push_ready
    );

endinterface

// single write port shared by all ways
interface array_wr_if import dcache_pkg::*; ();

    logic                         wr_en;
    logic                         tag_we;
    logic [$clog2(`DC_WAYS)-1:0]  way_sel;
    logic [DC_INDEX_W-1:0]        index;
    logic [DC_WORD_W-1:0]         word;
    dcache_tag_t                  tag;
    logic [31:0]                  wdata;
    logic [3:0]                   strb;

    modport ctrl (
        output wr_en, tag_we, way_sel, index, word, tag, wdata, strb
    );

    modport array (
        input  wr_en, tag_we, way_sel, index, word, tag, wdata, strb
    );

endinterface

//--- dcache_load_align.sv
`timescale 1ns/10ps
`include "dcache_settings.svh"

module dcache_load_align import dcache_pkg::*; (
    input  logic [`DC_WAYS-1:0]       way_hit_i,
    input  logic [`DC_WAYS-1:0][31:0] way_rdata_i,
    input  logic [31:0]               fwd_data_i,
    input  logic [3:0]                fwd_mask_i,
    input  logic [3:0]                rmask_i,
    input  mem_size_e                 size_i,
    input  logic                      signed_i,
    output logic [31:0]               data_o
);

    logic [31:0] array_word;
    logic [31:0] merged;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // zero when no way hits
    always_comb begin
        array_word = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (way_hit_i[w]) begin
                array_word = array_word | way_rdata_i[w];
            end
        end
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = fwd_mask_i[b] ? fwd_data_i[8*b +: 8] : array_word[8*b +: 8];
        end
    end

    always_comb begin
        sel_byte = '0;
        for (int b = 0; b < 4; b++) begin
            if (rmask_i[b]) begin
                sel_byte = merged[8*b +: 8];
            end
        end
        // upper half when lane 2 is requested
        sel_half = rmask_i[2] ? merged[31:16] : merged[15:0];
        case (size_i)
            MEM_BYTE: data_o = {{24{signed_i & sel_byte[7]}}, sel_byte};
            MEM_HALF: data_o = {{16{signed_i & sel_half[15]}}, sel_half};
            default:  data_o = merged;
        endcase
    end

endmodule

//--- dcache_pkg.sv
`include "dcache_settings.svh"

package dcache_pkg;

    localparam int unsigned DC_INDEX_W = $clog2(`DC_SETS);
    localparam int unsigned DC_WORD_W = $clog2(`DC_LINE_WORDS);
    localparam int unsigned DC_TAG_W = 32 - DC_INDEX_W - DC_WORD_W - 2;

    typedef logic [DC_TAG_W-1:0] dcache_tag_t;

    // field view of a physical address
    typedef struct packed {
        dcache_tag_t           tag;
        logic [DC_INDEX_W-1:0] index;
        logic [DC_WORD_W-1:0]  word;
        logic [1:0]            offset;
    } dcache_addr_fields_t;

    // raw word for store buffer matching, fields for array indexing
    typedef union packed {
        logic [31:0]         raw;
        dcache_addr_fields_t f;
    } dcache_addr_u;

    typedef struct packed {
        dcache_addr_u         addr;
        logic [31:0]          wdata;
        logic [3:0]           strb;
        logic [`DC_WAYS-1:0]  way_hit;
    } sb_entry_t;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

endpackage

//--- dcache_sb.sv
`timescale 1ns/10ps
`include "dcache_settings.svh"

module dcache_sb import dcache_pkg::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         flush_i,
    sb_push_if.sb        push,
    input  logic         pop_i,
    input  dcache_addr_u lookup_addr_i,
    output sb_entry_t    head_o,
    output logic         empty_o,
    output logic [31:0]  fwd_data_o,
    output logic [3:0]   fwd_mask_o
);

    localparam int unsigned PTR_W = $clog2(`DC_SB_DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;

    sb_entry_t           mem [`DC_SB_DEPTH];
    logic [PTR_W-1:0]    head_ptr;
    logic [PTR_W-1:0]    tail_ptr;
    logic [CNT_W-1:0]    count;
    logic                push_fire;
    logic                pop_fire;
    logic [PTR_W-1:0]    scan_idx;

    assign push.push_ready = (count != CNT_W'(`DC_SB_DEPTH));
    assign push_fire = push.push_valid && push.push_ready;
    assign pop_fire  = pop_i && (count != '0);
    assign empty_o   = (count == '0);
    assign head_o    = mem[head_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (flush_i) begin
            // uncommitted stores are dropped
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push_fire) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (pop_fire) begin
                head_ptr <= head_ptr + 1'b1;
            end
            count <= count + CNT_W'(push_fire) - CNT_W'(pop_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[tail_ptr] <= push.push_entry;
        end
    end

    // scan oldest to youngest so the youngest store wins per lane
    always_comb begin
        fwd_data_o = '0;
        fwd_mask_o = '0;
        scan_idx   = head_ptr;
        for (int i = 0; i < `DC_SB_DEPTH; i++) begin
            scan_idx = head_ptr + PTR_W'(i);
            if (CNT_W'(i) < count
                && mem[scan_idx].addr.raw[31:2] == lookup_addr_i.raw[31:2]) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem[scan_idx].strb[b]) begin
                        fwd_data_o[8*b +: 8] = mem[scan_idx].wdata[8*b +: 8];
                        fwd_mask_o[b]        = 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// number of ways, each way is 4 KiB
`define DC_WAYS 2

// sets per way
`define DC_SETS 256

// 32-bit words per 16-byte line
`define DC_LINE_WORDS 4

// store buffer entries, power of two
`define DC_SB_DEPTH 4

`endif

//--- dcache_top.sv
`timescale 1ns/10ps
`include "dcache_settings.svh"

module dcache_top import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        flush_i,
    input  logic        req_valid_i,
    output logic        req_ready_o,
    input  logic [31:0] req_addr_i,
    input  logic [31:0] req_wdata_i,
    input  logic [3:0]  req_strb_i,
    input  logic [3:0]  req_rmask_i,
    input  logic [1:0]  req_size_i,
    input  logic        req_signed_i,
    input  logic [3:0]  req_id_i,
    output logic        resp_valid_o,
    input  logic        resp_ready_i,
    output logic [3:0]  resp_id_o,
    output logic        resp_hit_o,
    output logic [31:0] resp_rdata_o,
    input  logic        fill_valid_i,
    input  logic        fill_way_i,
    input  logic [31:0] fill_addr_i,
    input  logic [31:0] fill_data_i,
    input  logic        fill_tag_we_i,
    input  logic        commit_i,
    output logic        sb_empty_o
);

    sb_push_if  sb_push ();
    array_wr_if arr_wr ();

    dcache_addr_u              rd_addr;
    dcache_addr_u              m1_addr;
    logic [3:0]                m1_rmask;
    mem_size_e                 m1_size;
    logic                      m1_signed;
    sb_entry_t                 sb_head;
    logic                      sb_pop;
    logic [`DC_WAYS-1:0]       way_hit;
    logic [`DC_WAYS-1:0][31:0] way_rdata;
    logic [31:0]               fwd_data;
    logic [3:0]                fwd_mask;
    logic [31:0]               load_data;

    dcache_ctrl u_ctrl (
        .clk, .rst_n_i, .flush_i,
        .req_valid_i, .req_ready_o, .req_addr_i, .req_wdata_i, .req_strb_i,
        .req_rmask_i, .req_size_i, .req_signed_i, .req_id_i,
        .resp_valid_o, .resp_ready_i, .resp_id_o, .resp_hit_o, .resp_rdata_o,
        .fill_valid_i, .fill_way_i, .fill_addr_i, .fill_data_i, .fill_tag_we_i,
        .commit_i,
        .push        (sb_push.ctrl),
        .wr          (arr_wr.ctrl),
        .sb_head_i   (sb_head),
        .sb_empty_i  (sb_empty_o),
        .pop_o       (sb_pop),
        .way_hit_i   (way_hit),
        .fwd_mask_i  (fwd_mask),
        .load_data_i (load_data),
        .rd_addr_o   (rd_addr),
        .m1_addr_o   (m1_addr),
        .m1_rmask_o  (m1_rmask),
        .m1_size_o   (m1_size),
        .m1_signed_o (m1_signed)
    );

    for (genvar i = 0; i < `DC_WAYS; i++) begin : g_way
        dcache_array #(.WAY_ID(i)) u_array (
            .clk, .rst_n_i,
            .rd_addr_i (rd_addr),
            .m1_tag_i  (m1_addr.f.tag),
            .wr        (arr_wr.array),
            .hit_o     (way_hit[i]),
            .rdata_o   (way_rdata[i])
        );
    end

    dcache_sb u_sb (
        .clk, .rst_n_i, .flush_i,
        .push          (sb_push.sb),
        .pop_i         (sb_pop),
        .lookup_addr_i (m1_addr),
        .head_o        (sb_head),
        .empty_o       (sb_empty_o),
        .fwd_data_o    (fwd_data),
        .fwd_mask_o    (fwd_mask)
    );

    dcache_load_align u_align (
        .way_hit_i   (way_hit),
        .way_rdata_i (way_rdata),
        .fwd_data_i  (fwd_data),
        .fwd_mask_i  (fwd_mask),
        .rmask_i     (m1_rmask),
        .size_i      (m1_size),
        .signed_i    (m1_signed),
        .data_o      (load_data)
    );

endmodule

//--- files.f
+incdir+.
dcache_pkg.sv
dcache_if.sv
dcache_array.sv
dcache_sb.sv
dcache_load_align.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache_sva.sv
tb_dcache.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache \
    -f files.f -o sim_dcache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_dcache)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

//--- tb_dcache.sv
`timescale 1ns/10ps
`include "dcache_settings.svh"

module tb_dcache import dcache_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int WAIT_LIMIT   = 20;
    // fills, requests and commits issued over all tests, rounded up
    localparam int OP_COUNT        = 64;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + OP_COUNT * (WAIT_LIMIT + 4);

    localparam logic [31:0] LINE_A     = 32'h0001_2340;
    localparam logic [31:0] LINE_B     = 32'h0005_6340;
    localparam logic [31:0] LINE_OTHER = 32'h0009_9340;
    localparam logic [31:0] LINE_EMPTY = 32'h0001_2580;

    logic clk, rst_n_i, flush_i;
    logic req_valid_i, req_ready_o, req_signed_i;
    logic [31:0] req_addr_i, req_wdata_i;
    logic [3:0] req_strb_i, req_rmask_i, req_id_i;
    logic [1:0] req_size_i;
    logic resp_valid_o, resp_ready_i, resp_hit_o;
    logic [3:0] resp_id_o;
    logic [31:0] resp_rdata_o;
    logic fill_valid_i, fill_way_i, fill_tag_we_i, commit_i, sb_empty_o;
    logic [31:0] fill_addr_i, fill_data_i;

    integer seed;
    int n_checks;
    int n_errors;
    logic [3:0] next_id;

    // line model per way and pending stores, oldest first
    logic        mdl_valid [`DC_WAYS][`DC_SETS];
    logic [19:0] mdl_tag   [`DC_WAYS][`DC_SETS];
    logic [31:0] mdl_data  [`DC_WAYS][`DC_SETS * `DC_LINE_WORDS];
    logic [31:0] sq_addr [$];
    logic [31:0] sq_data [$];
    logic [3:0]  sq_strb [$];
    logic [1:0]  sq_hit  [$];

    dcache_top u_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("timeout: the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic fail_note(input string what);
        n_errors++;
        $display("%s at %0t", what, $time);
    endtask

    function automatic logic [1:0] model_hits(input logic [31:0] addr);
        logic [1:0] hits;
        for (int w = 0; w < 2; w++) begin
            hits[w] = mdl_valid[w][addr[11:4]] && (mdl_tag[w][addr[11:4]] == addr[31:12]);
        end
        return hits;
    endfunction

    function automatic logic [3:0] lane_mask(input logic [31:0] addr, input mem_size_e size);
        case (size)
            MEM_BYTE: return 4'b0001 << addr[1:0];
            MEM_HALF: return addr[1] ? 4'b1100 : 4'b0011;
            default:  return 4'b1111;
        endcase
    endfunction

    // youngest pending store wins per byte, missed lines read as zero
    task automatic model_load(input logic [31:0] addr, input mem_size_e size, input logic sgn,
                              output logic [31:0] data, output logic hit);
        logic [1:0]  hits;
        logic [31:0] word;
        logic [3:0]  fmask;
        logic [3:0]  rmask;
        logic [7:0]  b;
        logic [15:0] h;
        hits  = model_hits(addr);
        rmask = lane_mask(addr, size);
        fmask = 4'b0000;
        word  = 32'd0;
        for (int w = 0; w < 2; w++) begin
            if (hits[w]) begin
                word = mdl_data[w][addr[11:2]];
            end
        end
        for (int i = 0; i < sq_addr.size(); i++) begin
            if (sq_addr[i][31:2] == addr[31:2]) begin
                for (int l = 0; l < 4; l++) begin
                    if (sq_strb[i][l]) begin
                        word[8*l +: 8] = sq_data[i][8*l +: 8];
                        fmask[l] = 1'b1;
                    end
                end
            end
        end
        hit = (|hits) || ((fmask & rmask) == rmask);
        b = word[8*addr[1:0] +: 8];
        h = addr[1] ? word[31:16] : word[15:0];
        case (size)
            MEM_BYTE: data = sgn ? {{24{b[7]}}, b} : {24'd0, b};
            MEM_HALF: data = sgn ? {{16{h[15]}}, h} : {16'd0, h};
            default:  data = word;
        endcase
    endtask

    task automatic fill_word(input logic way, input logic [31:0] addr, input logic [31:0] data,
                             input logic tag_we);
        @(posedge clk);
        #1;
        fill_valid_i  = 1'b1;
        fill_way_i    = way;
        fill_addr_i   = addr;
        fill_data_i   = data;
        fill_tag_we_i = tag_we;
        @(posedge clk);
        #1;
        fill_valid_i  = 1'b0;
        fill_tag_we_i = 1'b0;
        mdl_data[way][addr[11:2]] = data;
        if (tag_we) begin
            mdl_valid[way][addr[11:4]] = 1'b1;
            mdl_tag[way][addr[11:4]]   = addr[31:12];
        end
    endtask

    task automatic fill_line(input logic way, input logic [31:0] base);
        for (int w = 0; w < `DC_LINE_WORDS; w++) begin
            fill_word(way, base + 32'(4 * w), $random(seed), w == 0);
        end
    endtask

    // returns one ns after the accepting edge
    task automatic issue_req(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] strb, input mem_size_e size, input logic sgn);
        int waits;
        @(posedge clk);
        #1;
        req_valid_i  = 1'b1;
        req_addr_i   = addr;
        req_wdata_i  = wdata;
        req_strb_i   = strb;
        req_rmask_i  = (strb == 4'd0) ? lane_mask(addr, size) : 4'd0;
        req_size_i   = size;
        req_signed_i = sgn;
        req_id_i     = next_id;
        waits = 0;
        @(negedge clk);
        while (!req_ready_o && waits < WAIT_LIMIT) begin
            waits++;
            @(negedge clk);
        end
        if (!req_ready_o) begin
            fail_note("request was never accepted");
        end
        @(posedge clk);
        #1;
        req_valid_i = 1'b0;
    endtask

    task automatic wait_resp(output int waited);
        waited = 0;
        @(negedge clk);
        while (!resp_valid_o && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!resp_valid_o) begin
            fail_note("no response arrived");
        end
    endtask

    task automatic do_load(input logic [31:0] addr, input mem_size_e size, input logic sgn);
        logic [31:0] exp_data;
        logic        exp_hit;
        int          waited;
        issue_req(addr, 32'd0, 4'd0, size, sgn);
        model_load(addr, size, sgn, exp_data, exp_hit);
        wait_resp(waited);
        if (waited != 0) begin
            fail_note("load response did not come one cycle after acceptance");
        end
        check_eq("resp_id_o", resp_id_o, next_id);
        check_eq("resp_hit_o", resp_hit_o, exp_hit);
        check_eq("resp_rdata_o", resp_rdata_o, exp_data);
        next_id++;
    endtask

    task automatic finish_store(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] strb);
        logic [1:0] hits;
        int         waited;
        hits = model_hits(addr);
        wait_resp(waited);
        check_eq("resp_id_o", resp_id_o, next_id);
        check_eq("resp_hit_o", resp_hit_o, |hits);
        sq_addr.push_back(addr);
        sq_data.push_back(data);
        sq_strb.push_back(strb);
        sq_hit.push_back(hits);
        next_id++;
    endtask

    task automatic do_store(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        issue_req(addr, data, strb, MEM_WORD, 1'b0);
        finish_store(addr, data, strb);
    endtask

    task automatic commit_one();
        logic way;
        @(posedge clk);
        #1;
        commit_i = 1'b1;
        @(posedge clk);
        #1;
        commit_i = 1'b0;
        if (sq_addr.size() > 0) begin
            // oldest store lands in the way it hit, or nowhere
            if (sq_hit[0] != 2'b00) begin
                way = sq_hit[0][1];
                for (int l = 0; l < 4; l++) begin
                    if (sq_strb[0][l]) begin
                        mdl_data[way][sq_addr[0][11:2]][8*l +: 8] = sq_data[0][8*l +: 8];
                    end
                end
            end
            void'(sq_addr.pop_front());
            void'(sq_data.pop_front());
            void'(sq_strb.pop_front());
            void'(sq_hit.pop_front());
        end
    endtask

    task automatic drain_all();
        while (sq_addr.size() > 0) begin
            commit_one();
        end
        @(negedge clk);
        check_eq("sb_empty_o", sb_empty_o, 1'b1);
    endtask

    // call one ns after an edge
    task automatic flush_now();
        flush_i = 1'b1;
        @(negedge clk);
        check_eq("resp_valid_o", resp_valid_o, 1'b0);
        @(posedge clk);
        #1;
        flush_i = 1'b0;
        sq_addr.delete();
        sq_data.delete();
        sq_strb.delete();
        sq_hit.delete();
        @(negedge clk);
        check_eq("resp_valid_o", resp_valid_o, 1'b0);
        check_eq("sb_empty_o", sb_empty_o, 1'b1);
    endtask

    task automatic hit_loads();
        fill_line(1'b0, LINE_A);
        fill_line(1'b1, LINE_B);
        // both signs in every lane of one word
        fill_word(1'b0, LINE_A + 4, 32'h8c7f_f501, 1'b0);
        do_load(LINE_A + 4, MEM_WORD, 1'b0);
        do_load(LINE_B + 8, MEM_WORD, 1'b0);
        do_load(LINE_A + 6, MEM_HALF, 1'b1);
        do_load(LINE_A + 6, MEM_HALF, 1'b0);
        do_load(LINE_A + 4, MEM_HALF, 1'b1);
        do_load(LINE_A + 5, MEM_BYTE, 1'b1);
        do_load(LINE_A + 5, MEM_BYTE, 1'b0);
        do_load(LINE_A + 4, MEM_BYTE, 1'b1);
        do_load(LINE_B + 15, MEM_BYTE, 1'b1);
        do_load(LINE_B + 2, MEM_HALF, 1'b0);
    endtask

    task automatic miss_loads();
        do_load(LINE_EMPTY, MEM_WORD, 1'b0);
        do_load(LINE_OTHER + 4, MEM_WORD, 1'b0);
        do_store(LINE_EMPTY + 8, $random(seed), 4'b0011);
        // half covered by the store, word only partly
        do_load(LINE_EMPTY + 8, MEM_WORD, 1'b0);
        do_load(LINE_EMPTY + 8, MEM_HALF, 1'b1);
        drain_all();
        do_load(LINE_EMPTY + 8, MEM_WORD, 1'b0);
    endtask

    task automatic store_merge();
        do_store(LINE_A + 8, $random(seed), 4'b0011);
        do_store(LINE_A + 8, $random(seed), 4'b0110);
        do_load(LINE_A + 8, MEM_WORD, 1'b0);
        do_load(LINE_A + 9, MEM_BYTE, 1'b1);
        do_load(LINE_A + 10, MEM_HALF, 1'b0);
    endtask

    task automatic commit_drain();
        commit_one();
        do_load(LINE_A + 8, MEM_WORD, 1'b0);
        drain_all();
        do_load(LINE_A + 8, MEM_WORD, 1'b0);
        do_store(LINE_OTHER + 4, $random(seed), 4'b1111);
        drain_all();
        do_load(LINE_A + 4, MEM_WORD, 1'b0);
        do_load(LINE_B + 4, MEM_WORD, 1'b0);
    endtask

    task automatic back_pressure();
        logic [31:0] exp_data;
        logic [31:0] data5;
        logic        exp_hit;
        int          waited;
        @(posedge clk);
        #1;
        resp_ready_i = 1'b0;
        issue_req(LINE_B + 12, 32'd0, 4'd0, MEM_WORD, 1'b0);
        model_load(LINE_B + 12, MEM_WORD, 1'b0, exp_data, exp_hit);
        wait_resp(waited);
        repeat (4) begin
            @(negedge clk);
            check_eq("resp_valid_o", resp_valid_o, 1'b1);
            check_eq("resp_id_o", resp_id_o, next_id);
            check_eq("resp_hit_o", resp_hit_o, exp_hit);
            check_eq("resp_rdata_o", resp_rdata_o, exp_data);
            check_eq("req_ready_o", req_ready_o, 1'b0);
        end
        @(posedge clk);
        #1;
        resp_ready_i = 1'b1;
        next_id++;
        // four stores fill the buffer, the fifth waits for a commit
        for (int i = 0; i < `DC_SB_DEPTH; i++) begin
            do_store(LINE_B + 32'(4 * i), $random(seed), 4'b1111);
        end
        data5 = $random(seed);
        issue_req(LINE_B + 4, data5, 4'b1001, MEM_WORD, 1'b0);
        repeat (3) begin
            @(negedge clk);
            check_eq("resp_valid_o", resp_valid_o, 1'b0);
            check_eq("req_ready_o", req_ready_o, 1'b0);
        end
        commit_one();
        finish_store(LINE_B + 4, data5, 4'b1001);
        drain_all();
        do_load(LINE_B + 4, MEM_WORD, 1'b0);
    endtask

    task automatic drop_on_flush();
        do_store(LINE_A, $random(seed), 4'b1111);
        do_store(LINE_A + 12, $random(seed), 4'b0001);
        // a load sits in M1 when the flush hits
        issue_req(LINE_A, 32'd0, 4'd0, MEM_WORD, 1'b0);
        flush_now();
        next_id++;
        do_load(LINE_A, MEM_WORD, 1'b0);
        do_load(LINE_A + 12, MEM_BYTE, 1'b0);
    endtask

    initial begin
        seed = 99529;
        n_checks = 0;
        n_errors = 0;
        next_id = 4'd0;
        clk = 1'b0;
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        req_valid_i = 1'b0;
        req_addr_i = 32'd0;
        req_wdata_i = 32'd0;
        req_strb_i = 4'd0;
        req_rmask_i = 4'd0;
        req_size_i = 2'd0;
        req_signed_i = 1'b0;
        req_id_i = 4'd0;
        resp_ready_i = 1'b1;
        fill_valid_i = 1'b0;
        fill_way_i = 1'b0;
        fill_addr_i = 32'd0;
        fill_data_i = 32'd0;
        fill_tag_we_i = 1'b0;
        commit_i = 1'b0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                mdl_valid[w][s] = 1'b0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk);
        check_eq("resp_valid_o", resp_valid_o, 1'b0);
        check_eq("req_ready_o", req_ready_o, 1'b1);
        check_eq("sb_empty_o", sb_empty_o, 1'b1);
        hit_loads();
        miss_loads();
        store_merge();
        commit_drain();
        back_pressure();
        drop_on_flush();
        n_errors += u_dut.u_sva.n_fail;
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tb_dcache_sva.sv
`timescale 1ns/10ps

module tb_dcache_sva (
    input logic        clk,
    input logic        rst_n_i,
    input logic        flush_i,
    input logic        resp_valid_o,
    input logic        resp_ready_i,
    input logic [3:0]  resp_id_o,
    input logic        resp_hit_o,
    input logic [31:0] resp_rdata_o,
    input logic        push_valid_i,
    input logic        push_ready_i,
    input logic [31:0] m1_addr_i
);

    int unsigned n_fail = 0;

    // held response keeps its payload until taken or flushed
    resp_stable_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        resp_valid_o && !resp_ready_i && !flush_i |=> flush_i
            || (resp_valid_o && $stable(resp_id_o) && $stable(resp_hit_o)
                && $stable(resp_rdata_o)))
        else begin
            n_fail++;
            $error("response changed while it was held");
        end

    resp_low_in_reset_a: assert property (@(posedge clk) !rst_n_i |=> !resp_valid_o)
        else begin
            n_fail++;
            $error("response valid during reset");
        end

    // a stalled M1 keeps its request, so nothing new was taken in
    no_accept_in_stall_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        !flush_i && ((resp_valid_o && !resp_ready_i) || (push_valid_i && !push_ready_i))
            |=> $stable(m1_addr_i) && $stable(resp_id_o))
        else begin
            n_fail++;
            $error("request accepted while M1 was stalled");
        end

endmodule

bind dcache_top tb_dcache_sva u_sva (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_id_o    (resp_id_o),
    .resp_hit_o   (resp_hit_o),
    .resp_rdata_o (resp_rdata_o),
    .push_valid_i (sb_push.push_valid),
    .push_ready_i (sb_push.push_ready),
    .m1_addr_i    (m1_addr)
);
